// ==== logic/spi_reg_pkg.sv ====
package spi_reg_pkg;

   localparam int BYTE_W = 8;

   // Host register image, one byte per register
   typedef struct packed {
      logic [BYTE_W-1:0] cr0;    // idly[7:6] tdly[5:3] ldly[2:0]
      logic [BYTE_W-1:0] cr1;    // Port enable in bit 7
      logic [BYTE_W-1:0] cr2;    // Master and mode bits
      logic [BYTE_W-1:0] br;     // Divider in bits 5:0
      logic [BYTE_W-1:0] csr;    // Chip select mask, active low
      logic [BYTE_W-1:0] txdr;
   } spi_regs_t;

   // Single-cycle write strobes, same order as spi_regs_t
   typedef struct packed {
      logic cr0;
      logic cr1;
      logic cr2;
      logic br;
      logic csr;
      logic txdr;
   } spi_reg_wt_t;

   // Configuration fields as the datapath sees them
   typedef struct packed {
      logic              en;
      logic              mstr;
      logic              mcsh;     // Keep chip select low between bytes
      logic              cpol;
      logic              cpha;
      logic              lsbf;
      logic [5:0]        div;
      logic [2:0]        ldly;
      logic [2:0]        tdly;
      logic [1:0]        idly;
      logic [BYTE_W-1:0] csmask;
   } spi_cfg_t;

endpackage

// ==== logic/spi_ctl_pkg.sv ====
package spi_ctl_pkg;

   // Master sequencer states
   typedef enum logic [3:0] {
      mst_idle = 4'b0000,
      mst_cken = 4'b0001,
      mst_mcsn = 4'b0010,
      mst_ldly = 4'b0110,
      mst_mrun = 4'b0111,
      mst_tdly = 4'b0100,
      mst_rcsn = 4'b1100,
      mst_ckds = 4'b1001,
      mst_idly = 4'b1000
   } mst_state_e;

   // Which half of an SCK period a tick closes
   typedef enum logic {
      lead_edge  = 1'b0,
      trail_edge = 1'b1
   } shift_phase_e;

   // Single-cycle events between blocks
   typedef struct packed {
      logic tx_load;
      logic byte_done;
      logic cfg_wt;
   } spi_evt_t;

endpackage

// ==== logic/spi_host_regs.sv ====
`timescale 1ns/1ps

module spi_host_regs
   import spi_reg_pkg::*;
(
   input  logic              sb_clk_i,
   input  logic              spi_rst_async,
   input  spi_regs_t         regs_i,
   input  spi_reg_wt_t       reg_wt_i,
   input  logic              tx_load_i,
   output spi_cfg_t          cfg_o,
   output logic [BYTE_W-1:0] tx_byte_o,
   output logic              trdy_o,
   output logic              cfg_wt_o
);

   assign cfg_wt_o = reg_wt_i.cr0 | reg_wt_i.cr1 | reg_wt_i.cr2 | reg_wt_i.br | reg_wt_i.csr;

   // Configuration, decoded as it is written
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         cfg_o        <= '0;
         cfg_o.csmask <= '1;         // Nothing selected
      end else begin
         if (reg_wt_i.cr0) begin
            cfg_o.idly <= regs_i.cr0[7:6];
            cfg_o.tdly <= regs_i.cr0[5:3];
            cfg_o.ldly <= regs_i.cr0[2:0];
         end
         if (reg_wt_i.cr1) cfg_o.en <= regs_i.cr1[7];
         if (reg_wt_i.cr2) begin
            cfg_o.mstr <= regs_i.cr2[7];
            cfg_o.mcsh <= regs_i.cr2[6];
            cfg_o.cpol <= regs_i.cr2[2];
            cfg_o.cpha <= regs_i.cr2[1];
            cfg_o.lsbf <= regs_i.cr2[0];
         end
         if (reg_wt_i.br) cfg_o.div <= regs_i.br[5:0];
         if (reg_wt_i.csr) cfg_o.csmask <= regs_i.csr;
      end
   end

   // Transmit holding byte
   always_ff @(posedge sb_clk_i) begin
      if (reg_wt_i.txdr) tx_byte_o <= regs_i.txdr;
   end

   // A new write wins over a load in the same cycle, the old byte goes to the shifter
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         trdy_o <= 1'b1;
      end else if (cfg_wt_o) begin
         trdy_o <= 1'b1;             // Drops a pending byte
      end else if (reg_wt_i.txdr) begin
         trdy_o <= 1'b0;
      end else if (tx_load_i) begin
         trdy_o <= 1'b1;
      end
   end

endmodule

// ==== logic/spi_baud_gen.sv ====
`timescale 1ns/1ps

module spi_baud_gen
   import spi_ctl_pkg::*;
#(
   parameter int DIV_W = 6
) (
   input  logic             sb_clk_i,
   input  logic             spi_rst_async,
   input  logic             clk_en_i,
   input  logic             run_i,
   input  logic             cpol_i,
   input  logic [DIV_W-1:0] div_i,
   output logic             tick_o,
   output shift_phase_e     phase_o,
   output logic             sck_o
);

   logic [DIV_W-1:0] div_cnt;
   logic             sck_act;        // SCK away from its rest level

   // Half-period divider, one tick every div_i+1 cycles
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         div_cnt <= '0;
      end else if (!clk_en_i) begin
         div_cnt <= div_i;
      end else if (div_cnt == '0) begin
         div_cnt <= div_i;
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

   assign tick_o = clk_en_i & (div_cnt == '0);

   // Toggles only while shifting, back to rest after an even count
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         sck_act <= 1'b0;
      end else if (!run_i) begin
         sck_act <= 1'b0;
      end else if (tick_o) begin
         sck_act <= ~sck_act;
      end
   end

   // From rest the tick makes the leading edge
   assign phase_o = sck_act ? trail_edge : lead_edge;
   assign sck_o   = cpol_i ^ sck_act;

endmodule

// ==== logic/spi_master_fsm.sv ====
`timescale 1ns/1ps

module spi_master_fsm
   import spi_reg_pkg::*;
   import spi_ctl_pkg::*;
#(
   parameter int CS_W = 8
) (
   input  logic            sb_clk_i,
   input  logic            spi_rst_async,
   input  spi_cfg_t        cfg_i,
   input  logic            trdy_i,
   input  logic            cfg_wt_i,
   input  logic            txdr_wt_i,
   input  logic            tick_i,
   input  logic            byte_done_i,
   output logic            tx_load_o,
   output logic            shf_run_o,
   output logic            mclk_en_o,
   output logic            mclk_oe_o,
   output logic [CS_W-1:0] mcsn_o
);

   mst_state_e state;
   mst_state_e state_nxt;
   logic [3:0] dly_cnt;
   logic       no_cs;
   logic       start;
   logic       in_dly;
   logic       dly_done;
   logic       hold_go;

   assign no_cs    = &cfg_i.csmask;
   // A byte written now or left pending opens a frame
   assign start    = cfg_i.en & cfg_i.mstr & ~no_cs & ~cfg_wt_i & (txdr_wt_i | ~trdy_i);
   assign in_dly   = (state == mst_ldly) | (state == mst_tdly) | (state == mst_idly);
   assign dly_done = in_dly & tick_i & (dly_cnt == 4'd0);
   assign hold_go  = byte_done_i & cfg_i.mcsh & ~trdy_i;   // Next byte in the same frame

   // *******************************************************************
   // Master sequencer
   // *******************************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         mst_idle: if (start) state_nxt = mst_cken;
         mst_cken: state_nxt = mst_mcsn;
         mst_mcsn: state_nxt = mst_ldly;
         mst_ldly: if (dly_done) state_nxt = mst_mrun;
         mst_mrun: if (byte_done_i && !hold_go) state_nxt = mst_tdly;
         mst_tdly: if (dly_done) state_nxt = mst_rcsn;
         mst_rcsn: state_nxt = mst_ckds;
         mst_ckds: state_nxt = mst_idly;
         mst_idly: if (dly_done) state_nxt = mst_idle;
         default:  state_nxt = mst_idle;
      endcase
   end

   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         state <= mst_idle;
      end else begin
         state <= state_nxt;
      end
   end

   assign shf_run_o = (state == mst_mrun);
   assign tx_load_o = ((state == mst_ldly) & dly_done) | ((state == mst_mrun) & hold_go);

   // *******************************************************************
   // Lead, trail and idle delays, N+1 ticks each
   // *******************************************************************
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         dly_cnt <= 4'd0;
      end else if (state == mst_mcsn) begin
         dly_cnt <= {1'b0, cfg_i.ldly};
      end else if (state == mst_mrun) begin
         dly_cnt <= {1'b0, cfg_i.tdly};
      end else if (state == mst_rcsn) begin
         dly_cnt <= {2'b00, cfg_i.idly};
      end else if (in_dly && tick_i && dly_cnt != 4'd0) begin
         dly_cnt <= dly_cnt - 4'd1;
      end
   end

   // *******************************************************************
   // Clock enables and chip select
   // *******************************************************************
   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         mclk_en_o <= 1'b0;
         mclk_oe_o <= 1'b0;
         mcsn_o    <= '1;
      end else begin
         if (state == mst_cken) mclk_en_o <= 1'b1;
         else if ((state == mst_idly) && dly_done) mclk_en_o <= 1'b0;

         if (state == mst_cken) mclk_oe_o <= 1'b1;
         else if (state == mst_ckds) mclk_oe_o <= 1'b0;

         if (state == mst_mcsn) mcsn_o <= CS_W'(cfg_i.csmask);
         else if (state == mst_rcsn) mcsn_o <= '1;
      end
   end

endmodule

// ==== logic/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter
   import spi_reg_pkg::*;
   import spi_ctl_pkg::*;
(
   input  logic              sb_clk_i,
   input  logic              spi_rst_async,
   input  spi_cfg_t          cfg_i,
   input  logic              load_i,
   input  logic              run_i,
   input  logic              tick_i,
   input  shift_phase_e      phase_i,
   input  logic [BYTE_W-1:0] tx_byte_i,
   input  logic              miso_i,
   output logic              mosi_o,
   output logic              byte_done_o,
   output logic [BYTE_W-1:0] rx_byte_o
);

   logic [BYTE_W-1:0] shf_q;
   logic [3:0]        edge_cnt;
   logic              rx_bit;       // Sample waiting for the next shift
   logic              edge_tick;
   logic              smp_edge;
   logic              shf_edge;
   shift_phase_e      smp_phase;

   function automatic logic [BYTE_W-1:0] shift_in(input logic [BYTE_W-1:0] d,
                                                  input logic b,
                                                  input logic lsbf);
      return lsbf ? {b, d[BYTE_W-1:1]} : {d[BYTE_W-2:0], b};
   endfunction

   // cpha=0 samples on the leading edge, cpha=1 on the trailing one
   assign smp_phase = cfg_i.cpha ? trail_edge : lead_edge;
   assign edge_tick = run_i & tick_i;
   assign smp_edge  = edge_tick & (phase_i == smp_phase);
   // First leading edge with cpha=1 only presents the first bit
   assign shf_edge  = edge_tick & (phase_i != smp_phase) & (edge_cnt != 4'd0);

   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         edge_cnt <= 4'd0;
      end else if (load_i) begin
         edge_cnt <= 4'd0;
      end else if (edge_tick) begin
         edge_cnt <= edge_cnt + 4'd1;
      end
   end

   always_ff @(posedge sb_clk_i) begin
      if (smp_edge) rx_bit <= miso_i;
   end

   // Load wins over the last shift so a held frame runs on without a gap
   always_ff @(posedge sb_clk_i) begin
      if (load_i) begin
         shf_q <= tx_byte_i;
      end else if (shf_edge) begin
         shf_q <= shift_in(shf_q, rx_bit, cfg_i.lsbf);
      end
   end

   assign mosi_o      = cfg_i.lsbf ? shf_q[0] : shf_q[BYTE_W-1];
   assign byte_done_o = edge_tick & (edge_cnt == 4'd15);
   // With cpha=1 the last bit is sampled on the 16th edge itself
   assign rx_byte_o   = shift_in(shf_q, cfg_i.cpha ? miso_i : rx_bit, cfg_i.lsbf);

endmodule

// ==== logic/spi_rx_status.sv ====
`timescale 1ns/1ps

module spi_rx_status
   import spi_reg_pkg::*;
(
   input  logic              sb_clk_i,
   input  logic              spi_rst_async,
   input  logic              byte_done_i,
   input  logic              cfg_wt_i,
   input  logic              rxdr_rd_i,
   input  logic              trdy_i,
   input  logic              busy_i,
   input  logic              tip_i,
   input  logic [BYTE_W-1:0] rx_byte_i,
   output logic [BYTE_W-1:0] spirxdr_o,
   output logic [BYTE_W-1:0] spisr_o
);

   logic     rrdy_q;
   logic     roe_q;
   logic     busy_q;
   logic     tip_q;

   // Overwritten on every byte
   always_ff @(posedge sb_clk_i) begin
      if (byte_done_i) spirxdr_o <= rx_byte_i;
   end

   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         rrdy_q <= 1'b0;
         roe_q  <= 1'b0;
      end else if (rxdr_rd_i || cfg_wt_i) begin
         rrdy_q <= 1'b0;
         roe_q  <= 1'b0;
      end else if (byte_done_i) begin
         rrdy_q <= 1'b1;
         roe_q  <= roe_q | rrdy_q;      // Previous byte never read
      end
   end

   always_ff @(posedge sb_clk_i or posedge spi_rst_async) begin
      if (spi_rst_async) begin
         busy_q <= 1'b0;
         tip_q  <= 1'b0;
      end else begin
         busy_q <= busy_i;
         tip_q  <= tip_i;
      end
   end

   assign spisr_o = {tip_q, busy_q, 1'b0, trdy_i, rrdy_q, 1'b0, roe_q, 1'b0};

endmodule

// ==== logic/spi_master_port.sv ====
`timescale 1ns/1ps

module spi_master_port
   import spi_reg_pkg::*;
   import spi_ctl_pkg::*;
#(
   parameter int DIV_W = 6,
   parameter int CS_W  = 8
) (
   input  logic              sb_clk_i,
   input  logic              spi_rst_async,
   input  spi_regs_t         regs_i,
   input  spi_reg_wt_t       reg_wt_i,
   input  logic              rxdr_rd_i,
   input  logic              miso_i,
   output logic              mclk_o,
   output logic              mclk_oe_o,
   output logic              mosi_o,
   output logic              mosi_oe_o,
   output logic [CS_W-1:0]   mcsn_o,
   output logic [CS_W-1:0]   mcsn_oe_o,
   output logic [BYTE_W-1:0] spisr_o,
   output logic [BYTE_W-1:0] spirxdr_o
);

   spi_cfg_t          cfg;
   spi_evt_t          evt;
   logic [BYTE_W-1:0] tx_byte;
   logic [BYTE_W-1:0] rx_byte;
   logic              trdy;
   logic              shf_run;
   logic              mclk_en;
   logic              tick;
   shift_phase_e      phase;
   logic              mosi;
   logic              busy;

   // *******************************************************************
   // Input side
   // *******************************************************************
   spi_host_regs u_host_regs (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .regs_i        (regs_i),
      .reg_wt_i      (reg_wt_i),
      .tx_load_i     (evt.tx_load),
      .cfg_o         (cfg),
      .tx_byte_o     (tx_byte),
      .trdy_o        (trdy),
      .cfg_wt_o      (evt.cfg_wt)
   );

   // *******************************************************************
   // Sequencer, divider and shifter
   // *******************************************************************
   spi_master_fsm #(.CS_W(CS_W)) u_master_fsm (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .cfg_i         (cfg),
      .trdy_i        (trdy),
      .cfg_wt_i      (evt.cfg_wt),
      .txdr_wt_i     (reg_wt_i.txdr),
      .tick_i        (tick),
      .byte_done_i   (evt.byte_done),
      .tx_load_o     (evt.tx_load),
      .shf_run_o     (shf_run),
      .mclk_en_o     (mclk_en),
      .mclk_oe_o     (mclk_oe_o),
      .mcsn_o        (mcsn_o)
   );

   spi_baud_gen #(.DIV_W(DIV_W)) u_baud_gen (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .clk_en_i      (mclk_en),
      .run_i         (shf_run),
      .cpol_i        (cfg.cpol),
      .div_i         (DIV_W'(cfg.div)),
      .tick_o        (tick),
      .phase_o       (phase),
      .sck_o         (mclk_o)
   );

   spi_shifter u_shifter (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .cfg_i         (cfg),
      .load_i        (evt.tx_load),
      .run_i         (shf_run),
      .tick_i        (tick),
      .phase_i       (phase),
      .tx_byte_i     (tx_byte),
      .miso_i        (miso_i),
      .mosi_o        (mosi),
      .byte_done_o   (evt.byte_done),
      .rx_byte_o     (rx_byte)
   );

   // *******************************************************************
   // Output side
   // *******************************************************************
   spi_rx_status u_rx_status (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .byte_done_i   (evt.byte_done),
      .cfg_wt_i      (evt.cfg_wt),
      .rxdr_rd_i     (rxdr_rd_i),
      .trdy_i        (trdy),
      .busy_i        (busy),
      .tip_i         (shf_run),
      .rx_byte_i     (rx_byte),
      .spirxdr_o     (spirxdr_o),
      .spisr_o       (spisr_o)
   );

   assign busy      = ~&mcsn_o;        // Any slave selected
   assign mcsn_oe_o = ~mcsn_o;
   assign mosi_oe_o = shf_run;
   assign mosi_o    = mosi_oe_o ? mosi : 1'b1;   // Idles high when not driven

endmodule

// ==== tb/spi_master_props.sv ====
`timescale 1ns/1ps

module spi_master_props
   #(
   parameter int CS_W = 8
) (
   input  logic            sb_clk_i,
   input  logic            spi_rst_async,
   input  logic            cpol_i,
   input  logic            shf_run_i,
   input  logic            sck_i,
   input  logic            sck_oe_i,
   input  logic            mosi_oe_i,
   input  logic [CS_W-1:0] mcsn_i
);

   // *******************************************************************
   // Pin enable rules
   // *******************************************************************
   cs_needs_sck: assert property (@(posedge sb_clk_i) disable iff (spi_rst_async)
      !(&mcsn_i) |-> sck_oe_i)
      else $error("chip select active while the serial clock is not driven");

   mosi_needs_sck: assert property (@(posedge sb_clk_i) disable iff (spi_rst_async)
      mosi_oe_i |-> sck_oe_i)
      else $error("mosi driven while the serial clock is not");

   // SCK rests at cpol outside the shift phase
   sck_rest: assert property (@(posedge sb_clk_i) disable iff (spi_rst_async)
      !shf_run_i |-> (sck_i == cpol_i))
      else $error("serial clock away from its rest level while not shifting");

endmodule

bind spi_master_port spi_master_props #(.CS_W(CS_W)) u_props (
   .sb_clk_i      (sb_clk_i),
   .spi_rst_async (spi_rst_async),
   .cpol_i        (cfg.cpol),
   .shf_run_i     (shf_run),
   .sck_i         (mclk_o),
   .sck_oe_i      (mclk_oe_o),
   .mosi_oe_i     (mosi_oe_o),
   .mcsn_i        (mcsn_o)
);

// ==== tb/spi_master_tb.sv ====
`timescale 1ns/1ps

module spi_master_tb
   import spi_reg_pkg::*;
   import spi_ctl_pkg::*;
;

   localparam int DIV_W    = 6;
   localparam int CS_W     = 8;
   localparam int WAIT_MAX = 5000;
   localparam int N_ENT    = 10;

   // One transfer of the table
   typedef struct packed {
      logic [7:0] cr2;
      logic [7:0] br;
      logic [7:0] cr0;
      logic [7:0] csr;
      logic [7:0] tx;
      logic       rnd_src;    // 0 loopback, 1 random miso pattern
      logic [7:0] exp;
   } tbl_entry_t;

   logic              sb_clk_i;
   logic              spi_rst_async;
   spi_regs_t         regs_i;
   spi_reg_wt_t       reg_wt_i;
   logic              rxdr_rd_i;
   logic              miso_i;
   logic              mclk_o;
   logic              mclk_oe_o;
   logic              mosi_o;
   logic              mosi_oe_o;
   logic [CS_W-1:0]   mcsn_o;
   logic [CS_W-1:0]   mcsn_oe_o;
   logic [BYTE_W-1:0] spisr_o;
   logic [BYTE_W-1:0] spirxdr_o;

   tbl_entry_t tbl [N_ENT];
   integer     seed;
   int         err_cnt;
   logic       use_loop;
   logic       cur_cpol;
   logic       cur_cpha;
   logic       cur_lsbf;
   logic [7:0] cur_csr;
   logic       busy_seen;

   // Slave model state
   logic       sck_prev;
   logic [3:0] slv_idx;
   logic       slv_first;
   logic [7:0] slv_pat;
   logic       slv_bit;

   spi_master_port #(.DIV_W(DIV_W), .CS_W(CS_W)) UUT (
      .sb_clk_i      (sb_clk_i),
      .spi_rst_async (spi_rst_async),
      .regs_i        (regs_i),
      .reg_wt_i      (reg_wt_i),
      .rxdr_rd_i     (rxdr_rd_i),
      .miso_i        (miso_i),
      .mclk_o        (mclk_o),
      .mclk_oe_o     (mclk_oe_o),
      .mosi_o        (mosi_o),
      .mosi_oe_o     (mosi_oe_o),
      .mcsn_o        (mcsn_o),
      .mcsn_oe_o     (mcsn_oe_o),
      .spisr_o       (spisr_o),
      .spirxdr_o     (spirxdr_o)
   );

   initial begin
      sb_clk_i = 1'b0;
      forever #50 sb_clk_i = ~sb_clk_i;
   end

   // *******************************************************************
   // Slave model, same cpol and cpha rules as the master
   // *******************************************************************
   always @(negedge sb_clk_i) begin
      if (&mcsn_o) begin
         slv_idx   <= 4'd0;            // Frame closed, rewind
         slv_first <= 1'b1;
      end else if (mclk_o != sck_prev) begin
         if (mclk_o != cur_cpol) begin
            if (cur_cpha && slv_first) slv_first <= 1'b0;
            else if (cur_cpha) slv_idx <= slv_idx + 4'd1;
         end else if (!cur_cpha) begin
            slv_idx <= slv_idx + 4'd1;   // Next bit after trailing edge
         end
      end
      sck_prev <= mclk_o;
   end

   always_comb begin
      if (slv_idx < 4'd8) slv_bit = cur_lsbf ? slv_pat[slv_idx[2:0]] : slv_pat[3'd7 - slv_idx[2:0]];
      else slv_bit = 1'b0;
   end

   assign miso_i = use_loop ? mosi_o : slv_bit;

   task automatic fail_stop();
      err_cnt = err_cnt + 1;
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         fail_stop();
      end
   endtask

   task automatic set_config(input logic [7:0] cr0, input logic [7:0] cr2,
                             input logic [7:0] br, input logic [7:0] csr);
      @(negedge sb_clk_i);
      regs_i.cr0 = cr0;
      regs_i.cr1 = 8'h80;                // Port enable
      regs_i.cr2 = cr2;
      regs_i.br  = br;
      regs_i.csr = csr;
      reg_wt_i   = '{cr0: 1'b1, cr1: 1'b1, cr2: 1'b1, br: 1'b1, csr: 1'b1, txdr: 1'b0};
      cur_cpol   = cr2[2];
      cur_cpha   = cr2[1];
      cur_lsbf   = cr2[0];
      cur_csr    = csr;
      @(negedge sb_clk_i);
      reg_wt_i   = '0;
   endtask

   task automatic write_tx(input logic [7:0] b);
      @(negedge sb_clk_i);
      regs_i.txdr   = b;
      reg_wt_i.txdr = 1'b1;
      @(negedge sb_clk_i);
      reg_wt_i.txdr = 1'b0;
   endtask

   task automatic read_rx();
      @(negedge sb_clk_i);
      rxdr_rd_i = 1'b1;
      @(negedge sb_clk_i);
      rxdr_rd_i = 1'b0;
   endtask

   // Waits for a status bit, watching chip select on the way
   task automatic wait_status(input int idx, input logic val, input logic keep_cs);
      int n;
      n = 0;
      while (spisr_o[idx] !== val) begin
         @(negedge sb_clk_i);
         if (spisr_o[6]) busy_seen = 1'b1;
         if (mcsn_o != 8'hFF) begin
            check_eq("mcsn_o", mcsn_o, cur_csr);
            check_eq("mcsn_oe_o", mcsn_oe_o, ~cur_csr);
         end else begin
            assert (!keep_cs) else begin
               $display("chip select released inside a held frame");
               fail_stop();
            end
         end
         n = n + 1;
         if (n > WAIT_MAX) begin
            $display("timeout waiting for status bit %0d to become %0d", idx, val);
            fail_stop();
         end
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (UUT.u_master_fsm.state != mst_idle) begin
         @(negedge sb_clk_i);
         n = n + 1;
         if (n > WAIT_MAX) begin
            $display("timeout waiting for the master to return to idle");
            fail_stop();
         end
      end
   endtask

   task automatic check_closed();
      check_eq("mcsn_o", mcsn_o, 8'hFF);
      check_eq("mcsn_oe_o", mcsn_oe_o, 8'h00);
      check_eq("mclk_oe_o", {7'd0, mclk_oe_o}, 8'h00);
      check_eq("mclk_o", {7'd0, mclk_o}, {7'd0, cur_cpol});
      check_eq("busy", {7'd0, spisr_o[6]}, 8'h00);
   endtask

   task automatic run_entry(input tbl_entry_t e);
      integer     rnd;
      logic [7:0] exp;
      set_config(e.cr0, e.cr2, e.br, e.csr);
      use_loop = ~e.rnd_src;
      exp      = e.exp;
      if (e.rnd_src) begin
         rnd     = $random(seed);
         slv_pat = rnd[7:0];
         exp     = rnd[7:0];
      end
      busy_seen = 1'b0;
      write_tx(e.tx);
      check_eq("trdy", {7'd0, spisr_o[4]}, 8'h00);
      wait_status(3, 1'b1, 1'b0);
      check_eq("spirxdr_o", spirxdr_o, exp);
      check_eq("trdy", {7'd0, spisr_o[4]}, 8'h01);
      check_eq("busy_seen", {7'd0, busy_seen}, 8'h01);
      wait_idle();
      check_closed();
      read_rx();
      check_eq("rrdy", {7'd0, spisr_o[3]}, 8'h00);
   endtask

   initial begin
      int i;
      int n;
      seed          = 94334;
      err_cnt       = 0;
      regs_i        = '0;
      reg_wt_i      = '0;
      rxdr_rd_i     = 1'b0;
      use_loop      = 1'b1;
      slv_pat       = 8'h00;
      cur_cpol      = 1'b0;
      cur_cpha      = 1'b0;
      cur_lsbf      = 1'b0;
      cur_csr       = 8'hFF;
      busy_seen     = 1'b0;
      spi_rst_async = 1'b1;

      //        cr2    br     cr0    csr    tx     rnd   exp
      tbl[0] = '{8'h80, 8'h01, 8'h00, 8'hFE, 8'hA5, 1'b0, 8'hA5};
      tbl[1] = '{8'h82, 8'h00, 8'h09, 8'hFD, 8'h3C, 1'b0, 8'h3C};
      tbl[2] = '{8'h84, 8'h02, 8'h4A, 8'h7F, 8'hC3, 1'b0, 8'hC3};
      tbl[3] = '{8'h86, 8'h01, 8'hC7, 8'hF0, 8'h5A, 1'b0, 8'h5A};
      tbl[4] = '{8'h81, 8'h03, 8'h12, 8'hFE, 8'h96, 1'b0, 8'h96};
      tbl[5] = '{8'h87, 8'h00, 8'h00, 8'hEF, 8'h01, 1'b0, 8'h01};
      tbl[6] = '{8'h80, 8'h01, 8'h01, 8'hFE, 8'h00, 1'b1, 8'h00};
      tbl[7] = '{8'h83, 8'h02, 8'h08, 8'hFB, 8'hFF, 1'b1, 8'h00};
      tbl[8] = '{8'h84, 8'h00, 8'h00, 8'hDF, 8'h0F, 1'b1, 8'h00};
      tbl[9] = '{8'h87, 8'h01, 8'h52, 8'hFE, 8'hF0, 1'b1, 8'h00};

      repeat (16) @(negedge sb_clk_i);
      spi_rst_async = 1'b0;
      @(negedge sb_clk_i);
      check_closed();
      check_eq("spisr_o", spisr_o, 8'h10);
      check_eq("mosi_oe_o", {7'd0, mosi_oe_o}, 8'h00);

      for (i = 0; i < N_ENT; i++) run_entry(tbl[i]);

      // *******************************************************************
      // Held frame, two bytes under one chip select
      // *******************************************************************
      set_config(8'h08, 8'hC0, 8'h01, 8'hFB);
      use_loop = 1'b1;
      write_tx(8'h69);
      wait_status(4, 1'b1, 1'b0);
      write_tx(8'hD2);
      wait_status(3, 1'b1, 1'b0);
      check_eq("spirxdr_o", spirxdr_o, 8'h69);
      read_rx();
      check_eq("mcsn_o", mcsn_o, 8'hFB);
      wait_status(3, 1'b1, 1'b1);
      check_eq("spirxdr_o", spirxdr_o, 8'hD2);
      wait_idle();
      check_closed();
      read_rx();

      // Overrun when the first byte is never read
      set_config(8'h00, 8'h80, 8'h00, 8'hFE);
      write_tx(8'h11);
      wait_status(3, 1'b1, 1'b0);
      wait_idle();
      write_tx(8'h22);
      wait_status(1, 1'b1, 1'b0);
      check_eq("spirxdr_o", spirxdr_o, 8'h22);
      wait_idle();
      read_rx();
      check_eq("rrdy", {7'd0, spisr_o[3]}, 8'h00);
      check_eq("roe", {7'd0, spisr_o[1]}, 8'h00);

      // No slave selected, nothing may start
      set_config(8'h00, 8'h80, 8'h00, 8'hFF);
      write_tx(8'h44);
      for (n = 0; n < 200; n++) begin
         @(negedge sb_clk_i);
         check_eq("busy", {7'd0, spisr_o[6]}, 8'h00);
         check_eq("mcsn_o", mcsn_o, 8'hFF);
      end

      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
logic/spi_reg_pkg.sv
logic/spi_ctl_pkg.sv
logic/spi_host_regs.sv
logic/spi_baud_gen.sv
logic/spi_master_fsm.sv
logic/spi_shifter.sv
logic/spi_rx_status.sv
logic/spi_master_port.sv
tb/spi_master_props.sv
tb/spi_master_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module spi_master_tb -Mdir obj_dir \
   && ./obj_dir/Vspi_master_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
   && echo "run_sim: pass" && exit 0 \
   || { echo "run_sim: fail"; exit 1; }
